/* Bender.yml */
package:
  name: mem_scan

dependencies: {}

sources:
  - design/mem_scan_pkg.sv
  - design/dp_bram.sv
  - design/addr_counter.sv
  - design/scan_fsm.sv
  - design/sum_accum.sv
  - design/mem_scan_top.sv
  - target: simulation
    files:
      - sim/tb_mem_scan.sv

/* design/addr_counter.sv */
// ----------------------------------------------------------------------
// Port B address counter. Loaded with base and length at scan start,
// advances with wrap on each step and flags the last and empty counts.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module addr_counter import mem_scan_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load,   // take base and len from cmd
    input  scan_cmd_t         cmd,
    input  logic              step,   // one word read this cycle
    output logic [addr_w-1:0] addr,   // current port B address
    output logic              last,   // one word remains
    output logic              empty   // no words remain
);

    logic [addr_w-1:0] addr_q;
    logic [len_w-1:0]  remain_q;  // words still to read

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q   <= '0;
            remain_q <= '0;
        end else if (load) begin
            addr_q   <= cmd.base;
            remain_q <= cmd.len;
        end else if (step) begin
            addr_q   <= addr_q + 1'b1;    // wraps past the top word
            remain_q <= remain_q - 1'b1;
        end
    end

    assign addr  = addr_q;
    assign last  = (remain_q == len_w'(1));
    assign empty = (remain_q == '0);

    // the sequencer must stop stepping once the run is used up
    a_no_overstep: assert property (
        @(posedge clk) disable iff (!rst_n)
        step |-> !empty
    ) else $error("step with empty count at addr %0h", addr_q);

endmodule

/* design/dp_bram.sv */
// ----------------------------------------------------------------------
// Dual-port block RAM. Port A is the host read/write port with byte
// enables, port B is the read-only scan port with a valid strobe.
// Both outputs are registered and read-first.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module dp_bram import mem_scan_pkg::*; (
    input  logic              clk,
    input  host_req_t         host_req,  // port A request
    input  logic              enb,       // port B read enable
    input  logic [addr_w-1:0] addrb,     // port B address
    output logic [data_w-1:0] douta,     // port A read data
    output logic [data_w-1:0] doutb,     // port B read data
    output logic              validb     // doutb valid, enb one cycle late
);

    logic [data_w-1:0] ram [mem_depth];  // word storage, not reset
    logic [data_w-1:0] rdata_a;
    logic [data_w-1:0] rdata_b;
    logic              rd_strobe_b;

    // port A: byte writes plus capture of the old word
    always_ff @(posedge clk) begin
        if (host_req.en) begin
            for (int i = 0; i < be_w; i++) begin
                if (host_req.be[i]) begin
                    ram[host_req.addr][8*i +: 8] <= host_req.wdata[8*i +: 8];
                end
            end
            rdata_a <= ram[host_req.addr];  // old value, read-first
        end
    end

    // port B: read only
    always_ff @(posedge clk) begin
        rd_strobe_b <= enb;  // enb one cycle late
        if (enb) begin
            rdata_b <= ram[addrb];
        end
    end

    assign douta  = rdata_a;  // holds until next port A access
    assign doutb  = rdata_b;
    assign validb = rd_strobe_b;

    // scan reads and host writes must never collide on one word
    a_no_collision: assert property (
        @(posedge clk)
        (enb && host_req.en && (|host_req.be)) |-> (host_req.addr != addrb)
    ) else $error("port B read of addr %0h while port A writes it", addrb);

endmodule

/* design/mem_scan_pkg.sv */
// ----------------------------------------------------------------------
// Shared sizes and request types for the scanned memory block.
// Import with a wildcard in the module header of each user.
// ----------------------------------------------------------------------

package mem_scan_pkg;

    localparam int data_w    = 32;                 // memory word width
    localparam int be_w      = data_w / 8;         // one enable per byte
    localparam int mem_depth = 256;                // words in the memory
    localparam int addr_w    = $clog2(mem_depth);  // word address bits
    localparam int len_w     = addr_w + 1;         // full-memory count fits

    // port A request from the host, sampled on every clock edge
    typedef struct packed {
        logic              en;     // access strobe
        logic [be_w-1:0]   be;     // byte write enables, zero for pure read
        logic [addr_w-1:0] addr;   // word address
        logic [data_w-1:0] wdata;  // write data, lanes picked by be
    } host_req_t;

    // scan command, valid together with the start pulse
    typedef struct packed {
        logic [addr_w-1:0] base;   // first word read
        logic [len_w-1:0]  len;    // words to read, zero allowed
    } scan_cmd_t;

endpackage

/* design/mem_scan_top.sv */
// ----------------------------------------------------------------------
// Scanned memory block. Host port A reads and writes words, a scan
// engine sums a run of words over port B on each start pulse.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module mem_scan_top import mem_scan_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  host_req_t         host_req,    // port A request
    input  logic              scan_start,  // one-cycle pulse
    input  scan_cmd_t         scan_cmd,    // valid with scan_start
    output logic [data_w-1:0] host_rdata,  // port A read-first data
    output logic              scan_busy,
    output logic              scan_done,   // one-cycle result pulse
    output logic [data_w-1:0] scan_sum     // checksum, final at done
);

    logic              load;    // counter load and sum clear
    logic              step;    // port B enable and counter advance
    logic              last;
    logic              empty;
    logic [addr_w-1:0] addrb;
    logic [data_w-1:0] doutb;
    logic              validb;

    dp_bram u_bram (
        .clk      (clk),
        .host_req (host_req),
        .enb      (step),
        .addrb    (addrb),
        .douta    (host_rdata),
        .doutb    (doutb),
        .validb   (validb)
    );

    addr_counter u_addr_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .cmd   (scan_cmd),
        .step  (step),
        .addr  (addrb),
        .last  (last),
        .empty (empty)
    );

    scan_fsm u_scan_fsm (
        .clk   (clk),
        .rst_n (rst_n),
        .start (scan_start),
        .empty (empty),
        .last  (last),
        .load  (load),
        .step  (step),
        .busy  (scan_busy),
        .done  (scan_done)
    );

    sum_accum u_sum_accum (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (load),
        .valid (validb),
        .data  (doutb),
        .sum   (scan_sum)
    );

endmodule

/* design/scan_fsm.sv */
// ----------------------------------------------------------------------
// Scan sequencer. Loads the counter on start, steps port B until the
// last word, waits for the final valid word and pulses done.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module scan_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,  // one-cycle start request
    input  logic empty,  // counter has no words left
    input  logic last,   // counter has one word left
    output logic load,   // load counter, clear accumulator
    output logic step,   // port B enable and counter advance
    output logic busy,   // scan in progress
    output logic done    // one-cycle result pulse
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_drain
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   drain_wait;      // final valid word still in flight
    logic   drain_wait_nxt;

    always_comb begin
        state_nxt      = state;
        drain_wait_nxt = drain_wait;
        case (state)
            st_idle: begin
                if (start) state_nxt = st_read;  // counter loads this edge
            end
            st_read: begin
                if (empty || last) begin  // empty only for zero length
                    state_nxt      = st_drain;
                    drain_wait_nxt = last;  // one read still returning
                end
            end
            st_drain: begin
                if (drain_wait) drain_wait_nxt = 1'b0;
                else            state_nxt      = st_idle;
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            drain_wait <= 1'b0;
        end else begin
            state      <= state_nxt;
            drain_wait <= drain_wait_nxt;
        end
    end

    assign load = (state == st_idle) && start;  // start ignored when busy
    assign step = (state == st_read) && !empty;
    assign busy = (state == st_read) || ((state == st_drain) && drain_wait);
    assign done = (state == st_drain) && !drain_wait;  // busy already low

    // done only once the counter has run out of words
    a_done_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> empty
    ) else $error("done pulse with words left to read");

endmodule

/* design/sum_accum.sv */
// ----------------------------------------------------------------------
// Checksum accumulator. Cleared at scan start, adds every valid port B
// word, wraps modulo 2^32. The sum holds until the next clear.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module sum_accum import mem_scan_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear,  // start of a new scan
    input  logic              valid,  // data carries a scanned word
    input  logic [data_w-1:0] data,
    output logic [data_w-1:0] sum     // running checksum
);

    logic [data_w-1:0] sum_q;
    logic [data_w-1:0] sum_nxt;

    // add path, carry out dropped for modulo wrap
    assign sum_nxt = sum_q + data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_q <= '0;
        end else if (clear) begin
            sum_q <= '0;          // never overlaps valid in a scan
        end else if (valid) begin
            sum_q <= sum_nxt;
        end
    end

    assign sum = sum_q;  // stable after done

endmodule

/* list.f */
design/mem_scan_pkg.sv
design/dp_bram.sv
design/addr_counter.sv
design/scan_fsm.sv
design/sum_accum.sv
design/mem_scan_top.sv
sim/tb_mem_scan.sv

/* sim/tb_mem_scan.sv */
// ----------------------------------------------------------------------
// Directed testbench for the scanned memory block. Drives host port A
// and scan commands, checks read data and checksums against a model.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_mem_scan import mem_scan_pkg::*; ();

    logic              clk;
    logic              rst_n;
    host_req_t         host_req;
    logic              scan_start;
    scan_cmd_t         scan_cmd;
    logic [data_w-1:0] host_rdata;
    logic              scan_busy;
    logic              scan_done;
    logic [data_w-1:0] scan_sum;

    logic [data_w-1:0] shadow [mem_depth];  // memory model, X until written
    logic [addr_w-1:0] wr_q [$];            // addresses written during a scan
    integer            seed;
    int                errors;

    mem_scan_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .scan_start (scan_start),
        .scan_cmd   (scan_cmd),
        .host_rdata (host_rdata),
        .scan_busy  (scan_busy),
        .scan_done  (scan_done),
        .scan_sum   (scan_sum)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // byte-lane update of the model, same rule as port A
    function automatic void write_model(input logic [be_w-1:0] be,
                                        input logic [addr_w-1:0] addr,
                                        input logic [data_w-1:0] wdata);
        for (int i = 0; i < be_w; i++) begin
            if (be[i]) shadow[addr][8*i +: 8] = wdata[8*i +: 8];
        end
    endfunction

    function automatic logic [data_w-1:0] model_sum(input logic [addr_w-1:0] base,
                                                    input logic [len_w-1:0] len);
        logic [data_w-1:0] acc;
        acc = '0;
        for (int i = 0; i < len; i++) begin
            acc = acc + shadow[addr_w'(base + i)];  // wraps at 2^32 and past 255
        end
        return acc;
    endfunction

    // one port A access; old word must show up the next cycle
    task automatic host_access(input logic [be_w-1:0] be, input logic [addr_w-1:0] addr,
                               input logic [data_w-1:0] wdata);
        logic [data_w-1:0] exp_old;
        exp_old        = shadow[addr];
        host_req.en    = 1'b1;
        host_req.be    = be;
        host_req.addr  = addr;
        host_req.wdata = wdata;
        @(posedge clk);
        #1;
        host_req.en = 1'b0;
        if (host_rdata !== exp_old) begin
            $display("FAIL host_rdata addr 0x%h: expected 0x%h got 0x%h",
                     addr, exp_old, host_rdata);
            errors++;
        end
        write_model(be, addr, wdata);
    endtask

    // start a scan, optionally poke start again or write the host port meanwhile
    task automatic run_scan(input logic [addr_w-1:0] base, input logic [len_w-1:0] len,
                            input int dup_cyc, input bit host_wr);
        logic [data_w-1:0] exp_sum;
        logic [addr_w-1:0] wa;
        int                cyc;
        exp_sum       = model_sum(base, len);
        scan_cmd.base = base;
        scan_cmd.len  = len;
        scan_start    = 1'b1;
        @(posedge clk);  // cycle 0 edge
        #1;
        scan_start = 1'b0;
        cyc        = 1;
        while (!scan_done && cyc < 300) begin
            if (!scan_busy) begin
                $display("scan_busy dropped at cycle %0d of a scan of %0d words", cyc, len);
                errors++;
            end
            if (cyc == dup_cyc) begin
                scan_start    = 1'b1;  // must be ignored while busy
                scan_cmd.base = ~base;
                scan_cmd.len  = len_w'(5);
            end
            if (host_wr) begin
                wa             = addr_w'(base + len + 8 + cyc);  // clear of the scan run
                host_req.en    = 1'b1;
                host_req.be    = '1;
                host_req.addr  = wa;
                host_req.wdata = $random(seed);
                write_model(host_req.be, wa, host_req.wdata);
                wr_q.push_back(wa);
            end
            @(posedge clk);
            #1;
            scan_start  = 1'b0;
            host_req.en = 1'b0;
            cyc++;
        end
        if (!scan_done) begin
            $display("scan at base 0x%h timed out waiting for scan_done", base);
            errors++;
        end else begin
            if (cyc != len + 2) begin
                $display("FAIL scan_done cycle: expected 0x%h got 0x%h", len + 2, cyc);
                errors++;
            end
            if (scan_busy) begin
                $display("FAIL scan_busy at done: expected 0x0 got 0x%h", scan_busy);
                errors++;
            end
            if (scan_sum !== exp_sum) begin
                $display("FAIL scan_sum base 0x%h len 0x%h: expected 0x%h got 0x%h",
                         base, len, exp_sum, scan_sum);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        if (scan_done || scan_busy || scan_sum !== exp_sum) begin
            $display("scan engine did not settle idle with a stable sum after done");
            errors++;
        end
    endtask

    task automatic test_reset();
        if (scan_busy !== 1'b0 || scan_done !== 1'b0 || scan_sum !== '0) begin
            $display("FAIL reset state: busy 0x%h done 0x%h sum 0x%h",
                     scan_busy, scan_done, scan_sum);
            errors++;
        end
    endtask

    task automatic test_full_words();
        for (int a = 0; a < mem_depth; a++) host_access('1, addr_w'(a), $random(seed));
        for (int a = 0; a < mem_depth; a++) host_access('0, addr_w'(a), '0);
        @(posedge clk);
        #1;
        if (host_rdata !== shadow[mem_depth-1]) begin  // idle cycle keeps the last word
            $display("FAIL host_rdata hold: expected 0x%h got 0x%h",
                     shadow[mem_depth-1], host_rdata);
            errors++;
        end
    endtask

    task automatic test_byte_enables();
        logic [addr_w-1:0] a;
        logic [be_w-1:0]   be;
        for (int n = 0; n < 24; n++) begin
            a  = $random(seed);
            be = $random(seed);
            if (be == '0 || be == '1) be = 4'b0101;  // keep the mask partial
            host_access(be, a, $random(seed));
            host_access('0, a, '0);                  // read back merged word
        end
    endtask

    task automatic test_scans();
        run_scan($random(seed), len_w'(1 + ($random(seed) & 31)), 0, 1'b0);
        run_scan($random(seed), len_w'(1 + ($random(seed) & 63)), 0, 1'b0);
        run_scan(8'hf0, len_w'(40), 0, 1'b0);             // wraps past 255
        run_scan($random(seed), len_w'(mem_depth), 0, 1'b0);  // whole memory
    endtask

    task automatic test_zero_and_busy();
        run_scan($random(seed), '0, 0, 1'b0);
        run_scan($random(seed), len_w'(12), 2, 1'b0);  // second start mid-scan
    endtask

    task automatic test_host_during_scan();
        wr_q.delete();
        run_scan(8'h20, len_w'(24), 0, 1'b1);
        while (wr_q.size() > 0) host_access('0, wr_q.pop_front(), '0);
    endtask

    initial begin
        seed           = 32'hb4a1_86d2;
        errors         = 0;
        rst_n          = 1'b0;
        host_req       = '0;
        scan_start     = 1'b0;
        scan_cmd       = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_full_words();
        test_byte_enables();
        test_scans();
        test_zero_and_busy();
        test_host_during_scan();
        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
